//--- design/bj_game_pkg.sv
`default_nettype none

package bj_game_pkg;

	//////////////////////////////
	// Deck and card encoding
	//////////////////////////////

	// Cards in one deck
	localparam int DECK_SIZE = 52;

	// Index into the deck, value from the table
	typedef logic [5:0] card_idx_t;
	typedef logic [3:0] card_val_t;

	// Running hand total, wide enough for a bust
	typedef logic [4:0] hand_t;

	// One shift-register generator seed
	typedef logic [5:0] seed_t;

	// Blackjack and the dealer's stand point
	localparam hand_t HAND_LIMIT = 5'd21;
	localparam hand_t DEALER_STAND = 5'd17;

	//////////////////////////////
	// Results
	//////////////////////////////

	// Outcome from the player's side
	typedef enum logic [1:0] {
		RESULT_LOSS = 2'd0,
		RESULT_WIN = 2'd1,
		RESULT_TIE = 2'd2
	} game_result_t;

	// Card as handed from the draw unit to the player
	typedef struct packed {
		card_idx_t idx;
		card_val_t val;
	} card_t;

	// Per-lane result, valid until the next start
	typedef struct packed {
		logic valid;
		game_result_t outcome;
	} lane_result_t;

	//////////////////////////////
	// Lane FSM
	//////////////////////////////

	typedef enum logic [3:0] {
		LANE_IDLE,
		LANE_DEALER_HIDDEN,
		LANE_DEALER_CHECK,
		LANE_PLAYER_DECIDE,
		LANE_PLAYER_DRAW,
		LANE_DEALER_DECIDE,
		LANE_DEALER_DRAW,
		LANE_SCORE,
		LANE_HOLD
	} lane_state_t;

endpackage

`default_nettype wire

//--- design/bj_bus_pkg.sv
`default_nettype none

package bj_bus_pkg;

	localparam int BUS_ADDR_W = 8;
	localparam int BUS_DATA_W = 32;

	//////////////////////////////
	// Wishbone classic
	//////////////////////////////

	// Master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [BUS_ADDR_W-1:0] adr;
		logic [BUS_DATA_W-1:0] dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic ack;
		logic [BUS_DATA_W-1:0] dat;
	} wb_rsp_t;

	//////////////////////////////
	// Address map
	//////////////////////////////

	// Value table, one entry per card index
	localparam logic [BUS_ADDR_W-1:0] CARD_BASE = 8'h00;
	// Seed triples, one word per lane
	localparam logic [BUS_ADDR_W-1:0] SEED_BASE = 8'h40;
	localparam logic [BUS_ADDR_W-1:0] REG_PLAYER = 8'h80;
	localparam logic [BUS_ADDR_W-1:0] REG_DEALER_UP = 8'h81;
	// Bit 0 starts a run
	localparam logic [BUS_ADDR_W-1:0] REG_CONTROL = 8'h82;
	localparam logic [BUS_ADDR_W-1:0] REG_WINS = 8'h84;
	localparam logic [BUS_ADDR_W-1:0] REG_TIES = 8'h85;
	localparam logic [BUS_ADDR_W-1:0] REG_LOSSES = 8'h86;
	// Bit 0 is done
	localparam logic [BUS_ADDR_W-1:0] REG_STATUS = 8'h87;

	//////////////////////////////
	// Write data views
	//////////////////////////////

	// Three base seeds of a lane, s0 in the low bits
	typedef struct packed {
		bj_game_pkg::seed_t s2;
		bj_game_pkg::seed_t s1;
		bj_game_pkg::seed_t s0;
	} seed_triple_t;

	typedef struct packed {
		logic [27:0] pad;
		bj_game_pkg::card_val_t val;
	} card_word_t;

	typedef struct packed {
		logic [13:0] pad;
		seed_triple_t seeds;
	} seed_word_t;

	// Same write word, read by region
	typedef union packed {
		card_word_t card;
		seed_word_t seed;
	} load_word_u;

endpackage

`default_nettype wire

//--- design/card_loader.sv
`timescale 1ns/100ps
`default_nettype none

module card_loader #(
	parameter int NUM_LANES = 3
) (
	input wire CLOCK_50,
	input wire reset_in,
	input wire bj_bus_pkg::wb_req_t bus_req,
	input wire [31:0] wins,
	input wire [31:0] ties,
	input wire [31:0] losses,
	input wire done,
	output bj_bus_pkg::wb_rsp_t bus_rsp,
	output logic table_we,
	output bj_game_pkg::card_idx_t table_idx,
	output bj_game_pkg::card_val_t table_val,
	output bj_bus_pkg::seed_triple_t [NUM_LANES-1:0] seeds,
	output bj_game_pkg::hand_t player_start,
	output bj_game_pkg::card_val_t dealer_up,
	output logic start
);

	logic ack_q;
	logic write_fire;
	logic in_card;
	logic in_seed;
	logic [bj_bus_pkg::BUS_DATA_W-1:0] rd_data;
	bj_bus_pkg::load_word_u wr_word;

	// Request is held stable through the ack cycle
	assign write_fire = ack_q && bus_req.cyc && bus_req.stb && bus_req.we;
	assign wr_word = bus_req.dat;

	// Region decode
	assign in_card = bus_req.adr < bj_game_pkg::DECK_SIZE;
	assign in_seed = (bus_req.adr[7:6] == bj_bus_pkg::SEED_BASE[7:6])
		&& (bus_req.adr[5:0] < NUM_LANES);

	// Table write goes to every lane at once
	assign table_we = write_fire && in_card;
	assign table_idx = bus_req.adr[5:0];
	assign table_val = wr_word.card.val;

	//////////////////////////////
	// Handshake and start pulse
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset_in) begin
			ack_q <= 1'b0;
			start <= 1'b0;
		end else begin
			// One ack per request, never two in a row
			ack_q <= bus_req.cyc && bus_req.stb && !ack_q;
			// Lanes see start the cycle after the control ack
			start <= write_fire && (bus_req.adr == bj_bus_pkg::REG_CONTROL)
				&& bus_req.dat[0];
		end
	end

	// Configuration registers
	always_ff @(posedge CLOCK_50) begin
		if (write_fire) begin
			if (bus_req.adr == bj_bus_pkg::REG_PLAYER) begin
				player_start <= bus_req.dat[4:0];
			end
			// Up card fits the card view
			if (bus_req.adr == bj_bus_pkg::REG_DEALER_UP) begin
				dealer_up <= wr_word.card.val;
			end
			for (int lane = 0; lane < NUM_LANES; lane++) begin
				if (in_seed && (bus_req.adr[5:0] == lane)) begin
					seeds[lane] <= wr_word.seed.seeds;
				end
			end
		end
	end

	// Readback mux, table and seeds are write only
	always_comb begin
		case (bus_req.adr)
			bj_bus_pkg::REG_PLAYER: rd_data = 32'(player_start);
			bj_bus_pkg::REG_DEALER_UP: rd_data = 32'(dealer_up);
			bj_bus_pkg::REG_WINS: rd_data = wins;
			bj_bus_pkg::REG_TIES: rd_data = ties;
			bj_bus_pkg::REG_LOSSES: rd_data = losses;
			bj_bus_pkg::REG_STATUS: rd_data = {31'd0, done};
			default: rd_data = '0;
		endcase
	end

	assign bus_rsp = '{ack: ack_q, dat: rd_data};

	// An ack always answers a request that is still live
	ack_needs_request: assert property (@(posedge CLOCK_50) disable iff (reset_in)
		ack_q |-> bus_req.cyc && bus_req.stb);

endmodule

`default_nettype wire

//--- design/card_draw.sv
`timescale 1ns/100ps
`default_nettype none

module card_draw (
	input wire CLOCK_50,
	input wire reset_in,
	input wire start,
	input wire bj_bus_pkg::seed_triple_t seed,
	input wire table_we,
	input wire bj_game_pkg::card_idx_t table_idx,
	input wire bj_game_pkg::card_val_t table_val,
	input wire draw_req,
	output logic draw_done,
	output bj_game_pkg::card_t card
);

	localparam int NUM_GENS = 6;

	bj_game_pkg::seed_t gen_seed [NUM_GENS];
	bj_game_pkg::card_idx_t cand_idx;
	bj_game_pkg::card_val_t value_mem [64];
	logic [bj_game_pkg::DECK_SIZE-1:0] used;
	logic busy;
	logic step;
	logic in_deck;
	logic accept;

	// Three base seeds, then the pairwise XORs
	assign gen_seed[0] = seed.s0;
	assign gen_seed[1] = seed.s1;
	assign gen_seed[2] = seed.s2;
	assign gen_seed[3] = seed.s0 ^ seed.s1;
	assign gen_seed[4] = seed.s1 ^ seed.s2;
	assign gen_seed[5] = seed.s2 ^ seed.s0;

	//////////////////////////////
	// Index generators
	//////////////////////////////

	for (genvar k = 0; k < NUM_GENS; k++) begin : gen_lfsr
		bj_game_pkg::seed_t lfsr;

		// Shift left, feedback from bits 5 and 4
		always_ff @(posedge CLOCK_50) begin
			if (start) begin
				lfsr <= gen_seed[k];
			end else if (step) begin
				lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
			end
		end

		// One index bit per generator
		assign cand_idx[k] = lfsr[0];
	end

	// Out of deck or already dealt means step again
	assign in_deck = cand_idx < bj_game_pkg::DECK_SIZE;
	assign accept = busy && in_deck && !used[cand_idx];

	// First step on a new request, more while rejecting
	assign step = (!busy && !draw_done && draw_req) || (busy && !accept);

	//////////////////////////////
	// Draw control
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset_in || start) begin
			busy <= 1'b0;
			draw_done <= 1'b0;
			used <= '0;
		end else begin
			draw_done <= accept;
			// draw_req is still high during the done cycle, so skip it
			if (!busy && !draw_done && draw_req) begin
				busy <= 1'b1;
			end else if (accept) begin
				busy <= 1'b0;
				used[cand_idx] <= 1'b1;
			end
		end
	end

	// Broadcast table writes
	always_ff @(posedge CLOCK_50) begin
		if (table_we) begin
			value_mem[table_idx] <= table_val;
		end
	end

	// Card latched with its value on accept
	always_ff @(posedge CLOCK_50) begin
		if (accept) begin
			card.idx <= cand_idx;
			card.val <= value_mem[cand_idx];
		end
	end

	// Delivered card is in the deck and was free before this draw
	fresh_card: assert property (@(posedge CLOCK_50) disable iff (reset_in)
		draw_done |-> (card.idx < bj_game_pkg::DECK_SIZE) && used[card.idx]
			&& (($past(used) & (52'd1 << card.idx)) == '0));

endmodule

`default_nettype wire

//--- design/hand_player.sv
`timescale 1ns/100ps
`default_nettype none

module hand_player (
	input wire CLOCK_50,
	input wire reset_in,
	input wire start,
	input wire bj_game_pkg::hand_t player_start,
	input wire bj_game_pkg::card_val_t dealer_up,
	input wire draw_done,
	input wire bj_game_pkg::card_t card,
	output logic draw_req,
	output bj_game_pkg::lane_result_t result
);

	bj_game_pkg::lane_state_t state;
	bj_game_pkg::hand_t player_hand;
	bj_game_pkg::hand_t dealer_hand;
	bj_game_pkg::game_result_t outcome;
	logic up_low;
	logic up_mid;
	logic player_stands;
	logic player_drawing;
	bj_game_pkg::hand_t next_total;

	//////////////////////////////
	// Strategy and scoring
	//////////////////////////////

	// Up card bands for the fixed strategy
	assign up_low = (dealer_up >= 4'd2) && (dealer_up <= 4'd6);
	assign up_mid = (dealer_up >= 4'd4) && (dealer_up <= 4'd6);

	// Stand table, 17 and up also covers a bust
	assign player_stands = (player_hand >= bj_game_pkg::DEALER_STAND)
		|| ((player_hand >= 5'd13) && up_low)
		|| ((player_hand == 5'd12) && up_mid);

	always_comb begin
		if (player_hand > bj_game_pkg::HAND_LIMIT) begin
			outcome = bj_game_pkg::RESULT_LOSS;
		end else if (dealer_hand > bj_game_pkg::HAND_LIMIT) begin
			outcome = bj_game_pkg::RESULT_WIN;
		end else if (player_hand > dealer_hand) begin
			outcome = bj_game_pkg::RESULT_WIN;
		end else if (player_hand == dealer_hand) begin
			outcome = bj_game_pkg::RESULT_TIE;
		end else begin
			outcome = bj_game_pkg::RESULT_LOSS;
		end
	end

	// Which hand takes the card in flight
	assign player_drawing = (state == bj_game_pkg::LANE_PLAYER_DRAW);
	// Total after the card in flight
	assign next_total = (player_drawing ? player_hand : dealer_hand)
		+ {1'b0, card.val};

	// Hand totals
	always_ff @(posedge CLOCK_50) begin
		if (start) begin
			player_hand <= player_start;
			dealer_hand <= {1'b0, dealer_up};
		end else if (draw_done && draw_req) begin
			if (player_drawing) begin
				player_hand <= next_total;
			end else begin
				dealer_hand <= next_total;
			end
		end
	end

	//////////////////////////////
	// Lane FSM
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (reset_in) begin
			state <= bj_game_pkg::LANE_IDLE;
			draw_req <= 1'b0;
			result <= '0;
		end else if (start) begin
			// Hidden dealer card is the first draw
			state <= bj_game_pkg::LANE_DEALER_HIDDEN;
			draw_req <= 1'b1;
			result <= '0;
		end else begin
			case (state)
				bj_game_pkg::LANE_DEALER_HIDDEN: begin
					if (draw_done) begin
						draw_req <= 1'b0;
						state <= bj_game_pkg::LANE_DEALER_CHECK;
					end
				end
				// Dealer 21 skips player play
				bj_game_pkg::LANE_DEALER_CHECK: begin
					state <= (dealer_hand == bj_game_pkg::HAND_LIMIT)
						? bj_game_pkg::LANE_SCORE : bj_game_pkg::LANE_PLAYER_DECIDE;
				end
				bj_game_pkg::LANE_PLAYER_DECIDE: begin
					if (player_stands) begin
						state <= bj_game_pkg::LANE_DEALER_DECIDE;
					end else begin
						draw_req <= 1'b1;
						state <= bj_game_pkg::LANE_PLAYER_DRAW;
					end
				end
				bj_game_pkg::LANE_PLAYER_DRAW: begin
					if (draw_done) begin
						draw_req <= 1'b0;
						state <= bj_game_pkg::LANE_PLAYER_DECIDE;
					end
				end
				// Dealer hits below 17
				bj_game_pkg::LANE_DEALER_DECIDE: begin
					if (dealer_hand >= bj_game_pkg::DEALER_STAND) begin
						state <= bj_game_pkg::LANE_SCORE;
					end else begin
						draw_req <= 1'b1;
						state <= bj_game_pkg::LANE_DEALER_DRAW;
					end
				end
				bj_game_pkg::LANE_DEALER_DRAW: begin
					if (draw_done) begin
						draw_req <= 1'b0;
						state <= bj_game_pkg::LANE_DEALER_DECIDE;
					end
				end
				bj_game_pkg::LANE_SCORE: begin
					result <= '{valid: 1'b1, outcome: outcome};
					state <= bj_game_pkg::LANE_HOLD;
				end
				// Idle and hold wait for start
				default: begin
				end
			endcase
		end
	end

	// Every delivered card lands in one of the hand totals
	card_counted: assert property (@(posedge CLOCK_50) disable iff (reset_in)
		draw_done |-> draw_req);

endmodule

`default_nettype wire

//--- design/result_tally.sv
`timescale 1ns/100ps
`default_nettype none

module result_tally #(
	parameter int NUM_LANES = 3
) (
	input wire CLOCK_50,
	input wire reset_in,
	input wire start,
	input wire bj_game_pkg::lane_result_t [NUM_LANES-1:0] results,
	output logic [31:0] wins,
	output logic [31:0] ties,
	output logic [31:0] losses,
	output logic done
);

	// At least one bit for a single lane
	localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [LANE_W-1:0] lane;
	logic running;
	bj_game_pkg::lane_result_t cur;

	// Lanes are taken strictly in index order
	assign cur = results[lane];

	always_ff @(posedge CLOCK_50) begin
		if (reset_in || start) begin
			wins <= '0;
			ties <= '0;
			losses <= '0;
			lane <= '0;
			done <= 1'b0;
			running <= !reset_in;
		end else if (running && cur.valid) begin
			case (cur.outcome)
				bj_game_pkg::RESULT_WIN: wins <= wins + 32'd1;
				bj_game_pkg::RESULT_TIE: ties <= ties + 32'd1;
				default: losses <= losses + 32'd1;
			endcase
			// Last lane closes the run
			if (lane == LANE_W'(NUM_LANES - 1)) begin
				running <= 1'b0;
				done <= 1'b1;
			end else begin
				lane <= lane + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/blackjack_sim.sv
`timescale 1ns/100ps
`default_nettype none

module blackjack_sim #(
	parameter int NUM_LANES = 3
) (
	input wire CLOCK_50,
	input wire reset_in,
	input wire bj_bus_pkg::wb_req_t bus_req,
	output bj_bus_pkg::wb_rsp_t bus_rsp
);

	// Tally back to the bus
	logic [31:0] wins;
	logic [31:0] ties;
	logic [31:0] losses;
	logic done;

	// Configuration broadcast
	logic table_we;
	bj_game_pkg::card_idx_t table_idx;
	bj_game_pkg::card_val_t table_val;
	bj_bus_pkg::seed_triple_t [NUM_LANES-1:0] seeds;
	bj_game_pkg::hand_t player_start;
	bj_game_pkg::card_val_t dealer_up;
	logic start;

	bj_game_pkg::lane_result_t [NUM_LANES-1:0] results;

	card_loader #(
		.NUM_LANES(NUM_LANES)
	) u_loader (
		.CLOCK_50(CLOCK_50),
		.reset_in(reset_in),
		.bus_req(bus_req),
		.wins(wins),
		.ties(ties),
		.losses(losses),
		.done(done),
		.bus_rsp(bus_rsp),
		.table_we(table_we),
		.table_idx(table_idx),
		.table_val(table_val),
		.seeds(seeds),
		.player_start(player_start),
		.dealer_up(dealer_up),
		.start(start)
	);

	//////////////////////////////
	// Lanes
	//////////////////////////////

	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gen_lane
		logic draw_req;
		logic draw_done;
		bj_game_pkg::card_t card;

		// Own deck and generators per lane
		card_draw u_draw (
			.CLOCK_50(CLOCK_50),
			.reset_in(reset_in),
			.start(start),
			.seed(seeds[lane]),
			.table_we(table_we),
			.table_idx(table_idx),
			.table_val(table_val),
			.draw_req(draw_req),
			.draw_done(draw_done),
			.card(card)
		);

		hand_player u_player (
			.CLOCK_50(CLOCK_50),
			.reset_in(reset_in),
			.start(start),
			.player_start(player_start),
			.dealer_up(dealer_up),
			.draw_done(draw_done),
			.card(card),
			.draw_req(draw_req),
			.result(results[lane])
		);
	end

	result_tally #(
		.NUM_LANES(NUM_LANES)
	) u_tally (
		.CLOCK_50(CLOCK_50),
		.reset_in(reset_in),
		.start(start),
		.results(results),
		.wins(wins),
		.ties(ties),
		.losses(losses),
		.done(done)
	);

endmodule

`default_nettype wire

//--- verification/blackjack_tb.sv
`timescale 1ns/100ps
`default_nettype none

module blackjack_tb;

	localparam int NUM_LANES = 3;
	// Runs in the whole sequence and a budget per run
	localparam int NUM_RUNS = 14;
	localparam int RUN_BUDGET_NS = 14300;
	localparam int ACK_LIMIT = 16;
	localparam int DONE_POLL_LIMIT = 2000;

	logic CLOCK_50;
	logic reset_in;
	bj_bus_pkg::wb_req_t bus_req;
	bj_bus_pkg::wb_rsp_t bus_rsp;

	// Host side copy of the configuration
	bj_game_pkg::card_val_t card_table [bj_game_pkg::DECK_SIZE];
	bj_game_pkg::seed_t lane_seed [NUM_LANES][3];
	bj_game_pkg::hand_t player_total;
	bj_game_pkg::card_val_t up_card;

	int exp_wins;
	int exp_ties;
	int exp_losses;
	int got_wins;
	int got_ties;
	int got_losses;
	int access_count;
	int ack_count;
	event compare_ev;

	blackjack_sim #(
		.NUM_LANES(NUM_LANES)
	) UUT (
		.CLOCK_50(CLOCK_50),
		.reset_in(reset_in),
		.bus_req(bus_req),
		.bus_rsp(bus_rsp)
	);

	// 4 ns period
	always #2 CLOCK_50 = ~CLOCK_50;

	//////////////////////////////
	// Reporting
	//////////////////////////////

	task automatic report_error(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual)
		else report_error($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
			$time, name, expected, actual));
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// One card from the packed generators, -1 when the deck is exhausted
	function automatic int next_card(inout logic [35:0] gens, inout logic [51:0] used);
		logic [5:0] g;
		logic [5:0] idx;
		for (int tries = 0; tries < 64; tries++) begin
			// Step all six first
			for (int k = 0; k < 6; k++) begin
				g = gens[6*k +: 6];
				gens[6*k +: 6] = {g[4:0], g[5] ^ g[4]};
			end
			for (int k = 0; k < 6; k++) begin
				idx[k] = gens[6*k];
			end
			if ((idx < 6'd52) && !used[idx]) begin
				used[idx] = 1'b1;
				return int'(idx);
			end
		end
		return -1;
	endfunction

	function automatic logic player_stands(input int total, input int up);
		return (total >= 17) || ((total >= 13) && (up >= 2) && (up <= 6))
			|| ((total == 12) && (up >= 4) && (up <= 6));
	endfunction

	function automatic bj_game_pkg::game_result_t play_lane(
		input bj_game_pkg::card_val_t tbl [bj_game_pkg::DECK_SIZE],
		input bj_game_pkg::seed_t s0,
		input bj_game_pkg::seed_t s1,
		input bj_game_pkg::seed_t s2,
		input bj_game_pkg::hand_t start_total,
		input bj_game_pkg::card_val_t up,
		output logic feasible
	);
		logic [35:0] gens;
		logic [51:0] used;
		int dealer;
		int player;
		int c;
		// Generator 0 in the low bits, XOR pairs above the base seeds
		gens = {s2 ^ s0, s1 ^ s2, s0 ^ s1, s2, s1, s0};
		used = '0;
		feasible = 1'b1;
		dealer = int'(up);
		player = int'(start_total);
		// Hidden dealer card
		c = next_card(gens, used);
		if (c < 0) begin
			feasible = 1'b0;
			return bj_game_pkg::RESULT_LOSS;
		end
		dealer += int'(tbl[c]);
		// Dealer 21 goes straight to scoring
		if (dealer != 21) begin
			while (!player_stands(player, int'(up))) begin
				c = next_card(gens, used);
				if (c < 0) begin
					feasible = 1'b0;
					return bj_game_pkg::RESULT_LOSS;
				end
				player += int'(tbl[c]);
			end
			while (dealer < 17) begin
				c = next_card(gens, used);
				if (c < 0) begin
					feasible = 1'b0;
					return bj_game_pkg::RESULT_LOSS;
				end
				dealer += int'(tbl[c]);
			end
		end
		if (player > 21) return bj_game_pkg::RESULT_LOSS;
		if (dealer > 21) return bj_game_pkg::RESULT_WIN;
		if (player > dealer) return bj_game_pkg::RESULT_WIN;
		if (player == dealer) return bj_game_pkg::RESULT_TIE;
		return bj_game_pkg::RESULT_LOSS;
	endfunction

	//////////////////////////////
	// Bus access
	//////////////////////////////

	// Request on the rising edge, ack and data sampled on the falling edge
	task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited = 0;
		@(posedge CLOCK_50);
		bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(negedge CLOCK_50);
			waited++;
			assert (waited <= ACK_LIMIT)
			else report_error($sformatf("No ack for access to address %02h", adr));
		end while (!bus_rsp.ack);
		rdat = bus_rsp.dat;
		@(posedge CLOCK_50);
		bus_req <= '0;
		access_count++;
	endtask

	task automatic write_reg(input logic [7:0] adr, input logic [31:0] wdat);
		logic [31:0] unused;
		bus_access(1'b1, adr, wdat, unused);
	endtask

	task automatic read_reg(input logic [7:0] adr, output logic [31:0] rdat);
		bus_access(1'b0, adr, 32'd0, rdat);
	endtask

	// Every falling edge with ack high is one ack
	always @(negedge CLOCK_50) begin
		if (bus_rsp.ack) begin
			ack_count++;
		end
	end

	//////////////////////////////
	// Test steps
	//////////////////////////////

	task automatic load_table(input logic all_ten);
		int rank;
		for (int i = 0; i < bj_game_pkg::DECK_SIZE; i++) begin
			rank = i % 13;
			// Ace 11, faces 10
			if (all_ten) card_table[i] = 4'd10;
			else if (rank == 0) card_table[i] = 4'd11;
			else if (rank >= 9) card_table[i] = 4'd10;
			else card_table[i] = 4'(rank + 1);
			write_reg(8'(i), {28'd0, card_table[i]});
		end
	endtask

	task automatic load_config();
		for (int l = 0; l < NUM_LANES; l++) begin
			write_reg(8'(bj_bus_pkg::SEED_BASE + l),
				{14'd0, lane_seed[l][2], lane_seed[l][1], lane_seed[l][0]});
		end
		write_reg(bj_bus_pkg::REG_PLAYER, 32'(player_total));
		write_reg(bj_bus_pkg::REG_DEALER_UP, 32'(up_card));
	endtask

	// Fills the expected counts, returns 0 when a lane would run out of cards
	function automatic logic predict();
		logic ok;
		logic all_ok;
		bj_game_pkg::game_result_t r;
		all_ok = 1'b1;
		exp_wins = 0;
		exp_ties = 0;
		exp_losses = 0;
		for (int l = 0; l < NUM_LANES; l++) begin
			r = play_lane(card_table, lane_seed[l][0], lane_seed[l][1], lane_seed[l][2],
				player_total, up_card, ok);
			all_ok = all_ok && ok;
			if (r == bj_game_pkg::RESULT_WIN) exp_wins++;
			else if (r == bj_game_pkg::RESULT_TIE) exp_ties++;
			else exp_losses++;
		end
		return all_ok;
	endfunction

	task automatic start_and_check();
		logic [31:0] st;
		logic [31:0] rd;
		int polls;
		assert (predict())
		else report_error("Reference deck ran out of cards for a lane");
		write_reg(bj_bus_pkg::REG_CONTROL, 32'd1);
		// Poll status until done
		polls = 0;
		do begin
			read_reg(bj_bus_pkg::REG_STATUS, st);
			polls++;
			assert (polls < DONE_POLL_LIMIT)
			else report_error("Run never raised done");
		end while (!st[0]);
		read_reg(bj_bus_pkg::REG_WINS, rd);
		got_wins = int'(rd);
		read_reg(bj_bus_pkg::REG_TIES, rd);
		got_ties = int'(rd);
		read_reg(bj_bus_pkg::REG_LOSSES, rd);
		got_losses = int'(rd);
		-> compare_ev;
		// Compare runs before the next run changes the expectations
		@(posedge CLOCK_50);
	endtask

	task automatic pick_random_config();
		bj_game_pkg::seed_t s [3];
		do begin
			for (int l = 0; l < NUM_LANES; l++) begin
				// Distinct nonzero seeds give nonzero XOR pairs
				s[0] = 6'($urandom_range(63, 1));
				do s[1] = 6'($urandom_range(63, 1)); while (s[1] == s[0]);
				do s[2] = 6'($urandom_range(63, 1)); while (s[2] == s[0] || s[2] == s[1]);
				for (int k = 0; k < 3; k++) lane_seed[l][k] = s[k];
			end
			player_total = 5'($urandom_range(20, 4));
			up_card = 4'($urandom_range(11, 2));
		end while (!predict());
	endtask

	task automatic fixed_seeds();
		lane_seed[0] = '{6'd5, 6'd18, 6'd33};
		lane_seed[1] = '{6'd11, 6'd40, 6'd27};
		lane_seed[2] = '{6'd61, 6'd9, 6'd22};
	endtask

	//////////////////////////////
	// Compare and watchdog
	//////////////////////////////

	always @(compare_ev) begin
		check_value("wins", exp_wins, got_wins);
		check_value("ties", exp_ties, got_ties);
		check_value("losses", exp_losses, got_losses);
		check_value("count sum", NUM_LANES, got_wins + got_ties + got_losses);
	end

	initial begin
		#(NUM_RUNS * RUN_BUDGET_NS);
		report_error("Watchdog expired before the tests finished");
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		logic [31:0] rd;
		void'($urandom(32'h303d13b6));
		CLOCK_50 = 1'b0;
		reset_in = 1'b1;
		bus_req = '0;
		access_count = 0;
		ack_count = 0;
		repeat (3) @(posedge CLOCK_50);
		reset_in <= 1'b0;

		// Register readback and unmapped read
		write_reg(bj_bus_pkg::REG_PLAYER, 32'd14);
		read_reg(bj_bus_pkg::REG_PLAYER, rd);
		check_value("player_start", 14, int'(rd));
		write_reg(bj_bus_pkg::REG_DEALER_UP, 32'd9);
		read_reg(bj_bus_pkg::REG_DEALER_UP, rd);
		check_value("dealer_up", 9, int'(rd));
		read_reg(8'h90, rd);
		check_value("unmapped read", 0, int'(rd));
		@(negedge CLOCK_50);
		check_value("ack_count", access_count, ack_count);

		// Standard table, fixed seeds
		load_table(1'b0);
		fixed_seeds();
		player_total = 5'd15;
		up_card = 4'd10;
		load_config();
		start_and_check();

		// Random seeds and hands
		repeat (10) begin
			pick_random_config();
			load_config();
			start_and_check();
		end

		// All tens against an ace up, dealer 21 every time
		load_table(1'b1);
		fixed_seeds();
		player_total = 5'd15;
		up_card = 4'd11;
		load_config();
		assert (predict() && exp_losses == NUM_LANES)
		else report_error("Reference does not lose every lane on dealer 21");
		start_and_check();

		// Restart without reload must clear and repeat the reference counts
		load_table(1'b0);
		player_total = 5'd13;
		up_card = 4'd7;
		load_config();
		start_and_check();
		start_and_check();

		@(negedge CLOCK_50);
		check_value("ack_count", access_count, ack_count);
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- blackjack_sim.f
design/bj_game_pkg.sv
design/bj_bus_pkg.sv
design/card_loader.sv
design/card_draw.sv
design/hand_player.sv
design/result_tally.sv
design/blackjack_sim.sv
verification/blackjack_tb.sv

//--- Makefile
# Verilator build and run for the blackjack lane simulator

VERILATOR ?= verilator
TOP       ?= blackjack_tb
FILELIST  ?= blackjack_sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
EXTRA     ?=

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
